// File: common/emif_cfg.svh
`ifndef EMIF_CFG_SVH
`define EMIF_CFG_SVH

// user side word
`define EMIF_WORD_W     32

// words per memory line, lane 0 is the top word
`define EMIF_LANES      8
`define EMIF_LANE_W     3

// one memory line and its byte enables
`define EMIF_LINE_W     256
`define EMIF_BE_W       32

// word address = {line address, lane}
`define EMIF_WADDR_W    25
`define EMIF_LADDR_W    22

// write word count, 1 to 255
`define EMIF_LEN_W      8

`endif

// File: common/emif_pkg.sv
`include "emif_cfg.svh"
`default_nettype none

package emif_pkg;

    // user write command
    typedef struct packed {
        logic [`EMIF_WADDR_W-1:0] addr;  // first word
        logic [`EMIF_LEN_W-1:0]   len;   // 1 to 255 words
    } wr_cmd_t;

    // user read command, all words inside one line
    typedef struct packed {
        logic [`EMIF_WADDR_W-1:0] addr;
        logic [`EMIF_LANE_W:0]    len;   // 1 to 8 words
    } rd_cmd_t;

    // contents of one lane of the line being built
    typedef struct packed {
        logic                    valid;
        logic [`EMIF_WORD_W-1:0] word;
    } lane_t;

    // one line operation for the emif port
    typedef struct packed {
        logic                     write;  // low for a line read
        logic [`EMIF_LADDR_W-1:0] addr;
        logic [`EMIF_LINE_W-1:0]  data;
        logic [`EMIF_BE_W-1:0]    be;
    } line_cmd_t;

endpackage

`default_nettype wire

// File: write_path/word_distributor.sv
`timescale 1ns/1ps
`include "emif_cfg.svh"
`default_nettype none

module word_distributor
    import emif_pkg::*;
(
    input  wire                       ddr_emif_clk,
    input  wire                       ddr_emif_rst_n,
    input  wire                       wr_req,
    input  wire wr_cmd_t              wr_cmd,
    output logic                      wr_ack,
    input  wire [`EMIF_WORD_W-1:0]    wr_word,
    input  wire                       wr_word_valid,
    output logic                      wr_word_ready,
    input  wire                       line_busy,
    output logic [`EMIF_LANES-1:0]    lane_load,
    output logic [`EMIF_WORD_W-1:0]   lane_word,
    output logic                      line_close,
    output logic [`EMIF_LADDR_W-1:0]  line_addr
);

    logic                     active;      // words of the current command still due
    logic [`EMIF_WADDR_W-1:0] cur_addr;
    logic [`EMIF_LEN_W-1:0]   remain;
    logic                     capture;
    logic                     accept;
    logic                     closes_now;

    assign capture    = wr_req && !wr_ack && !active;
    assign closes_now = (&cur_addr[`EMIF_LANE_W-1:0]) || (remain == 1);  // lane 7 or last word

    // closing word waits while the previous line is still queued,
    // and one bubble while the lanes clear
    assign wr_word_ready = active && !line_close && !(line_busy && closes_now);
    assign accept        = wr_word_valid && wr_word_ready;
    assign lane_word     = wr_word;

    always_comb begin
        lane_load = '0;
        lane_load[cur_addr[`EMIF_LANE_W-1:0]] = accept;  // one-hot lane select
    end

    always_ff @(posedge ddr_emif_clk) begin
        if (!ddr_emif_rst_n) begin
            wr_ack     <= 1'b0;
            active     <= 1'b0;
            line_close <= 1'b0;
        end else begin
            line_close <= accept && closes_now;
            if (capture) begin
                wr_ack <= 1'b1;
                active <= 1'b1;
            end else if (!wr_req) begin
                wr_ack <= 1'b0;
            end
            if (accept && remain == 1)
                active <= 1'b0;
        end
    end

    always_ff @(posedge ddr_emif_clk) begin
        if (capture) begin
            cur_addr <= wr_cmd.addr;
            remain   <= wr_cmd.len;
        end else if (accept) begin
            cur_addr <= cur_addr + 1'b1;  // carries into the next line
            remain   <= remain - 1'b1;
        end
        if (accept && closes_now)
            line_addr <= cur_addr[`EMIF_WADDR_W-1:`EMIF_LANE_W];
    end

    a_load_onehot: assert property (@(posedge ddr_emif_clk) disable iff (!ddr_emif_rst_n)
        $onehot0(lane_load));

endmodule

`default_nettype wire

// File: write_path/word_lane.sv
`timescale 1ns/1ps
`include "emif_cfg.svh"
`default_nettype none

module word_lane
    import emif_pkg::*;
(
    input  wire                     ddr_emif_clk,
    input  wire                     ddr_emif_rst_n,
    input  wire                     load,
    input  wire [`EMIF_WORD_W-1:0]  word,
    input  wire                     clear,
    output lane_t                   lane
);

    logic                    valid_q;
    logic [`EMIF_WORD_W-1:0] word_q;

    always_ff @(posedge ddr_emif_clk) begin
        if (!ddr_emif_rst_n) begin
            valid_q <= 1'b0;
        end else if (clear) begin
            valid_q <= 1'b0;  // line handed over
        end else if (load) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge ddr_emif_clk) begin
        if (load)
            word_q <= word;
    end

    assign lane = '{valid: valid_q, word: word_q};

    // distributor leaves a bubble on the close cycle
    a_no_load_on_clear: assert property (@(posedge ddr_emif_clk) disable iff (!ddr_emif_rst_n)
        !(load && clear));

endmodule

`default_nettype wire

// File: write_path/line_writer.sv
`timescale 1ns/1ps
`include "emif_cfg.svh"
`default_nettype none

module line_writer
    import emif_pkg::*;
(
    input  wire                         ddr_emif_clk,
    input  wire                         ddr_emif_rst_n,
    input  wire lane_t [`EMIF_LANES-1:0] lanes,
    input  wire                         line_close,
    input  wire [`EMIF_LADDR_W-1:0]     line_addr,
    output logic                        line_busy,
    output line_cmd_t                   wr_line,
    output logic                        wr_line_valid,
    input  wire                         wr_line_grant
);

    localparam int LANES  = `EMIF_LANES;
    localparam int WORD_W = `EMIF_WORD_W;
    localparam int BE_LN  = `EMIF_BE_W / `EMIF_LANES;  // byte enables per lane

    line_cmd_t next_line;

    // lane 0 lands in the most significant word
    always_comb begin
        next_line       = '0;
        next_line.write = 1'b1;
        next_line.addr  = line_addr;
        for (int i = 0; i < LANES; i++) begin
            if (lanes[i].valid)
                next_line.data[(LANES-1-i)*WORD_W +: WORD_W] = lanes[i].word;
            next_line.be[(LANES-1-i)*BE_LN +: BE_LN] = {BE_LN{lanes[i].valid}};
        end
    end

    always_ff @(posedge ddr_emif_clk) begin
        if (!ddr_emif_rst_n) begin
            wr_line_valid <= 1'b0;
        end else if (line_close) begin
            wr_line_valid <= 1'b1;
        end else if (wr_line_grant) begin
            wr_line_valid <= 1'b0;  // taken by the port
        end
    end

    always_ff @(posedge ddr_emif_clk) begin
        if (line_close)
            wr_line <= next_line;
    end

    assign line_busy = wr_line_valid;  // one line of holding

    // the distributor never closes onto a held line
    a_no_overwrite: assert property (@(posedge ddr_emif_clk) disable iff (!ddr_emif_rst_n)
        line_close |-> !wr_line_valid);

    a_grant_when_held: assert property (@(posedge ddr_emif_clk) disable iff (!ddr_emif_rst_n)
        wr_line_grant |-> wr_line_valid);

endmodule

`default_nettype wire

// File: source/read_unpacker.sv
`timescale 1ns/1ps
`include "emif_cfg.svh"
`default_nettype none

module read_unpacker
    import emif_pkg::*;
(
    input  wire                      ddr_emif_clk,
    input  wire                      ddr_emif_rst_n,
    input  wire                      rd_req,
    input  wire rd_cmd_t             rd_cmd,
    output logic                     rd_ack,
    output line_cmd_t                rd_line,
    output logic                     rd_line_valid,
    input  wire                      rd_line_grant,
    input  wire [`EMIF_LINE_W-1:0]   ddr_emif_read_data,
    input  wire                      ddr_emif_rddata_valid,
    output logic [`EMIF_WORD_W-1:0]  rd_word,
    output logic                     rd_valid
);

    typedef enum logic [2:0] {ST_IDLE, ST_REQ, ST_WAIT, ST_STREAM, ST_ACK} state_t;

    state_t                   state;
    logic [`EMIF_LADDR_W-1:0] raddr_q;
    logic [`EMIF_LANE_W-1:0]  lane_idx;   // next lane to return
    logic [`EMIF_LANE_W:0]    remain;
    logic [`EMIF_LINE_W-1:0]  line_q;

    assign rd_line       = '{write: 1'b0, addr: raddr_q, data: '0, be: '0};
    assign rd_line_valid = (state == ST_REQ);
    assign rd_valid      = (state == ST_STREAM);
    assign rd_ack        = (state == ST_ACK);
    assign rd_word       = line_q[(`EMIF_LANES-1-lane_idx)*`EMIF_WORD_W +: `EMIF_WORD_W];

    always_ff @(posedge ddr_emif_clk) begin
        if (!ddr_emif_rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE:   if (rd_req) state <= ST_REQ;
                ST_REQ:    if (rd_line_grant) state <= ST_WAIT;
                ST_WAIT:   if (ddr_emif_rddata_valid) state <= ST_STREAM;
                ST_STREAM: if (remain == 1) state <= ST_ACK;  // last word out now
                ST_ACK:    if (!rd_req) state <= ST_IDLE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge ddr_emif_clk) begin
        case (state)
            ST_IDLE: begin
                if (rd_req) begin
                    raddr_q  <= rd_cmd.addr[`EMIF_WADDR_W-1:`EMIF_LANE_W];
                    lane_idx <= rd_cmd.addr[`EMIF_LANE_W-1:0];
                    remain   <= rd_cmd.len;
                end
            end
            ST_WAIT: if (ddr_emif_rddata_valid) line_q <= ddr_emif_read_data;
            ST_STREAM: begin
                lane_idx <= lane_idx + 1'b1;
                remain   <= remain - 1'b1;
            end
            default: ;
        endcase
    end

    a_inside_line: assert property (@(posedge ddr_emif_clk) disable iff (!ddr_emif_rst_n)
        (state == ST_IDLE && rd_req) |->
            (rd_cmd.len != 0 && rd_cmd.addr[`EMIF_LANE_W-1:0] + rd_cmd.len <= `EMIF_LANES));

    // one line read outstanding at a time
    a_data_when_waiting: assert property (@(posedge ddr_emif_clk) disable iff (!ddr_emif_rst_n)
        ddr_emif_rddata_valid |-> state == ST_WAIT);

endmodule

`default_nettype wire

// File: source/emif_port_mux.sv
`timescale 1ns/1ps
`include "emif_cfg.svh"
`default_nettype none

module emif_port_mux
    import emif_pkg::*;
(
    input  wire                      ddr_emif_clk,
    input  wire                      ddr_emif_rst_n,
    input  wire line_cmd_t           wr_line,
    input  wire                      wr_line_valid,
    output logic                     wr_line_grant,
    input  wire line_cmd_t           rd_line,
    input  wire                      rd_line_valid,
    output logic                     rd_line_grant,
    input  wire                      ddr_emif_ready,
    output logic                     ddr_emif_write,
    output logic                     ddr_emif_read,
    output logic [`EMIF_LADDR_W-1:0] ddr_emif_addr,
    output logic [`EMIF_LINE_W-1:0]  ddr_emif_write_data,
    output logic [`EMIF_BE_W-1:0]    ddr_emif_byte_enable
);

    logic      wr_pend;
    logic      rd_pend;
    logic      port_free;
    line_cmd_t pick;

    assign wr_line_grant = ddr_emif_write && ddr_emif_ready;
    assign rd_line_grant = ddr_emif_read && ddr_emif_ready;

    // a granted requester still shows valid on the grant cycle
    assign wr_pend   = wr_line_valid && !wr_line_grant;
    assign rd_pend   = rd_line_valid && !rd_line_grant;
    assign port_free = !(ddr_emif_write || ddr_emif_read) || ddr_emif_ready;
    assign pick      = wr_pend ? wr_line : rd_line;  // writes first

    always_ff @(posedge ddr_emif_clk) begin
        if (!ddr_emif_rst_n) begin
            ddr_emif_write <= 1'b0;
            ddr_emif_read  <= 1'b0;
        end else if (port_free) begin
            ddr_emif_write <= (wr_pend || rd_pend) && pick.write;
            ddr_emif_read  <= (wr_pend || rd_pend) && !pick.write;
        end
    end

    always_ff @(posedge ddr_emif_clk) begin
        if (port_free && (wr_pend || rd_pend)) begin
            ddr_emif_addr        <= pick.addr;
            ddr_emif_write_data  <= pick.data;
            ddr_emif_byte_enable <= pick.be;
        end
    end

    a_one_op: assert property (@(posedge ddr_emif_clk) disable iff (!ddr_emif_rst_n)
        !(ddr_emif_write && ddr_emif_read));

endmodule

`default_nettype wire

// File: source/ddr3_emif_buffer.sv
`timescale 1ns/1ps
`include "emif_cfg.svh"
`default_nettype none

module ddr3_emif_buffer
    import emif_pkg::*;
(
    input  wire                      ddr_emif_clk,
    input  wire                      ddr_emif_rst_n,
    // user write side
    input  wire                      wr_req,
    input  wire wr_cmd_t             wr_cmd,
    output logic                     wr_ack,
    input  wire [`EMIF_WORD_W-1:0]   wr_word,
    input  wire                      wr_word_valid,
    output logic                     wr_word_ready,
    // user read side
    input  wire                      rd_req,
    input  wire rd_cmd_t             rd_cmd,
    output logic                     rd_ack,
    output logic [`EMIF_WORD_W-1:0]  rd_word,
    output logic                     rd_valid,
    // emif port
    input  wire                      ddr_emif_ready,
    input  wire [`EMIF_LINE_W-1:0]   ddr_emif_read_data,
    input  wire                      ddr_emif_rddata_valid,
    output logic                     ddr_emif_write,
    output logic                     ddr_emif_read,
    output logic [`EMIF_LADDR_W-1:0] ddr_emif_addr,
    output logic [`EMIF_LINE_W-1:0]  ddr_emif_write_data,
    output logic [`EMIF_BE_W-1:0]    ddr_emif_byte_enable
);

    logic [`EMIF_LANES-1:0]   lane_load;
    logic [`EMIF_WORD_W-1:0]  lane_word;
    lane_t [`EMIF_LANES-1:0]  lanes;
    logic                     line_close;
    logic [`EMIF_LADDR_W-1:0] line_addr;
    logic                     line_busy;
    line_cmd_t                wr_line;
    logic                     wr_line_valid;
    logic                     wr_line_grant;
    line_cmd_t                rd_line;
    logic                     rd_line_valid;
    logic                     rd_line_grant;

    word_distributor u_distributor (
        .ddr_emif_clk, .ddr_emif_rst_n, .wr_req, .wr_cmd, .wr_ack, .wr_word,
        .wr_word_valid, .wr_word_ready, .line_busy, .lane_load, .lane_word,
        .line_close, .line_addr
    );

    // one register per lane of the line being filled
    for (genvar i = 0; i < `EMIF_LANES; i++) begin : g_lane
        word_lane u_lane (
            .ddr_emif_clk, .ddr_emif_rst_n,
            .load  (lane_load[i]),
            .word  (lane_word),
            .clear (line_close),
            .lane  (lanes[i])
        );
    end

    line_writer u_line_writer (
        .ddr_emif_clk, .ddr_emif_rst_n, .lanes, .line_close, .line_addr,
        .line_busy, .wr_line, .wr_line_valid, .wr_line_grant
    );

    read_unpacker u_read_unpacker (
        .ddr_emif_clk, .ddr_emif_rst_n, .rd_req, .rd_cmd, .rd_ack, .rd_line,
        .rd_line_valid, .rd_line_grant, .ddr_emif_read_data, .ddr_emif_rddata_valid,
        .rd_word, .rd_valid
    );

    emif_port_mux u_port_mux (
        .ddr_emif_clk, .ddr_emif_rst_n, .wr_line, .wr_line_valid, .wr_line_grant,
        .rd_line, .rd_line_valid, .rd_line_grant, .ddr_emif_ready, .ddr_emif_write,
        .ddr_emif_read, .ddr_emif_addr, .ddr_emif_write_data, .ddr_emif_byte_enable
    );

endmodule

`default_nettype wire

// File: bench/emif_checker.sv
`timescale 1ns/1ps
`include "emif_cfg.svh"
`default_nettype none

module emif_checker
    import emif_pkg::*;
(
    input  wire                      ddr_emif_clk,
    input  wire                      ddr_emif_rst_n,
    input  wire wr_cmd_t             wr_cmd,
    input  wire                      wr_ack,
    input  wire [`EMIF_WORD_W-1:0]   wr_word,
    input  wire                      wr_word_valid,
    input  wire                      wr_word_ready,
    input  wire                      rd_req,
    input  wire rd_cmd_t             rd_cmd,
    input  wire                      rd_ack,
    input  wire [`EMIF_WORD_W-1:0]   rd_word,
    input  wire                      rd_valid,
    input  wire                      ddr_emif_ready,
    input  wire                      ddr_emif_write,
    input  wire                      ddr_emif_read,
    input  wire [`EMIF_LADDR_W-1:0]  ddr_emif_addr,
    input  wire [`EMIF_LINE_W-1:0]   ddr_emif_write_data,
    input  wire [`EMIF_BE_W-1:0]     ddr_emif_byte_enable
);

    int errors = 0;
    int pending_lines = 0;                  // lines expected on the port but not seen yet

    logic [31:0]  ref_mem [int];            // reference words by word address
    logic [24:0]  w_addr;
    int           w_left;
    logic [255:0] exp_data;
    logic [31:0]  exp_be;
    logic [21:0]  exp_addr_q [$];
    logic [255:0] exp_data_q [$];
    logic [31:0]  exp_be_q [$];
    logic [31:0]  rd_exp_q [$];
    logic [21:0]  rd_line_exp;
    bit           streaming;
    logic         prev_wr_ack;
    logic         prev_rd_req;
    logic         prev_rd_ack;
    logic         held;                     // command waited for ready last cycle
    logic         held_wr;
    logic         held_rd;
    logic [21:0]  held_addr;
    logic [255:0] held_data;
    logic [31:0]  held_be;

    // unwritten memory content, same rule as the emif model
    function automatic logic [31:0] fill_word(input logic [24:0] a);
        return {7'h2d, a};
    endfunction

    task automatic report_value(input string name, input logic [255:0] got,
                                input logic [255:0] exp);
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    always @(negedge ddr_emif_clk) begin
        logic [2:0]   lane;
        logic [255:0] mask;
        logic [24:0]  wa;
        if (!ddr_emif_rst_n) begin
            prev_wr_ack = 0;
            prev_rd_req = 0;
            prev_rd_ack = 0;
            streaming   = 0;
            held        = 0;
        end else begin
            if (wr_ack && !prev_wr_ack) begin
                w_addr   = wr_cmd.addr;
                w_left   = wr_cmd.len;
                exp_data = '0;
                exp_be   = '0;
            end
            if (wr_word_valid && wr_word_ready) begin
                lane = w_addr[2:0];
                ref_mem[int'(w_addr)] = wr_word;
                exp_data[(7-lane)*32 +: 32] = wr_word;  // lane 0 on top
                exp_be[(7-lane)*4 +: 4]     = 4'hf;
                if (lane == 3'd7 || w_left == 1) begin
                    exp_addr_q.push_back(w_addr[24:3]);
                    exp_data_q.push_back(exp_data);
                    exp_be_q.push_back(exp_be);
                    pending_lines++;
                    exp_data = '0;
                    exp_be   = '0;
                end
                w_addr = w_addr + 1;
                w_left--;
            end
            // a command waiting for ready must not change
            if (held) begin
                if (ddr_emif_write !== held_wr)
                    report_value("ddr_emif_write", ddr_emif_write, held_wr);
                if (ddr_emif_read !== held_rd)
                    report_value("ddr_emif_read", ddr_emif_read, held_rd);
                if (ddr_emif_addr !== held_addr)
                    report_value("ddr_emif_addr", ddr_emif_addr, held_addr);
                if (ddr_emif_write_data !== held_data)
                    report_value("ddr_emif_write_data", ddr_emif_write_data, held_data);
                if (ddr_emif_byte_enable !== held_be)
                    report_value("ddr_emif_byte_enable", ddr_emif_byte_enable, held_be);
            end
            held      = (ddr_emif_write || ddr_emif_read) && !ddr_emif_ready;
            held_wr   = ddr_emif_write;
            held_rd   = ddr_emif_read;
            held_addr = ddr_emif_addr;
            held_data = ddr_emif_write_data;
            held_be   = ddr_emif_byte_enable;
            if (ddr_emif_write && ddr_emif_ready) begin
                if (exp_addr_q.size() == 0) begin
                    $display("line write at %0t that no user write asked for", $time);
                    errors++;
                end else begin
                    for (int b = 0; b < 32; b++)
                        mask[b*8 +: 8] = {8{ddr_emif_byte_enable[b]}};
                    if (ddr_emif_addr !== exp_addr_q[0])
                        report_value("ddr_emif_addr", ddr_emif_addr, exp_addr_q[0]);
                    if (ddr_emif_byte_enable !== exp_be_q[0])
                        report_value("ddr_emif_byte_enable", ddr_emif_byte_enable, exp_be_q[0]);
                    if ((ddr_emif_write_data & mask) !== exp_data_q[0])
                        report_value("ddr_emif_write_data", ddr_emif_write_data & mask,
                                     exp_data_q[0]);
                    void'(exp_addr_q.pop_front());
                    void'(exp_data_q.pop_front());
                    void'(exp_be_q.pop_front());
                    pending_lines--;
                end
            end
            if (rd_req && !prev_rd_req) begin
                rd_exp_q.delete();
                rd_line_exp = rd_cmd.addr[24:3];
                for (int i = 0; i < rd_cmd.len; i++) begin
                    wa = {rd_cmd.addr[24:3], 3'(rd_cmd.addr[2:0] + i)};
                    rd_exp_q.push_back(ref_mem.exists(int'(wa)) ? ref_mem[int'(wa)]
                                                                 : fill_word(wa));
                end
                streaming = 0;
            end
            if (ddr_emif_read && ddr_emif_ready && ddr_emif_addr !== rd_line_exp)
                report_value("ddr_emif_addr", ddr_emif_addr, rd_line_exp);
            if (rd_valid) begin
                if (rd_exp_q.size() == 0) begin
                    $display("more read words than requested at %0t", $time);
                    errors++;
                end else begin
                    if (rd_word !== rd_exp_q[0])
                        report_value("rd_word", rd_word, rd_exp_q[0]);
                    void'(rd_exp_q.pop_front());
                end
                streaming = 1;
            end else if (streaming && rd_exp_q.size() != 0) begin
                $display("read words not on consecutive cycles at %0t", $time);
                errors++;
                streaming = 0;
            end else if (streaming && !rd_ack) begin
                $display("rd_ack did not follow the last read word at %0t", $time);
                errors++;
                streaming = 0;
            end
            if (rd_ack && !prev_rd_ack) begin
                if (rd_exp_q.size() != 0) begin
                    $display("rd_ack at %0t before all words came back", $time);
                    errors++;
                end
                streaming = 0;
            end
            prev_wr_ack = wr_ack;
            prev_rd_req = rd_req;
            prev_rd_ack = rd_ack;
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_ddr3_emif_buffer.sv
`timescale 1ns/1ps
`include "emif_cfg.svh"
`default_nettype none

module tb_ddr3_emif_buffer
    import emif_pkg::*;
;

    localparam int TIMEOUT = 2000;

    logic                     ddr_emif_clk;
    logic                     ddr_emif_rst_n;
    logic                     wr_req;
    wr_cmd_t                  wr_cmd;
    logic                     wr_ack;
    logic [`EMIF_WORD_W-1:0]  wr_word;
    logic                     wr_word_valid;
    logic                     wr_word_ready;
    logic                     rd_req;
    rd_cmd_t                  rd_cmd;
    logic                     rd_ack;
    logic [`EMIF_WORD_W-1:0]  rd_word;
    logic                     rd_valid;
    logic                     ddr_emif_ready;
    logic [`EMIF_LINE_W-1:0]  ddr_emif_read_data;
    logic                     ddr_emif_rddata_valid;
    logic                     ddr_emif_write;
    logic                     ddr_emif_read;
    logic [`EMIF_LADDR_W-1:0] ddr_emif_addr;
    logic [`EMIF_LINE_W-1:0]  ddr_emif_write_data;
    logic [`EMIF_BE_W-1:0]    ddr_emif_byte_enable;

    logic [31:0]  rng_state = 32'hd4b8;
    logic [255:0] line_mem [int];   // emif model storage by line address
    int           rd_delay = 0;
    logic [21:0]  rd_addr;
    int           bench_errors = 0;

    ddr3_emif_buffer UUT (.*);
    emif_checker u_checker (.*);

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [255:0] model_line(input logic [21:0] a);
        logic [255:0] l;
        if (line_mem.exists(int'(a)))
            return line_mem[int'(a)];
        for (int i = 0; i < 8; i++)
            l[(7-i)*32 +: 32] = {7'h2d, a, 3'(i)};  // fill from word address
        return l;
    endfunction

    initial begin
        ddr_emif_clk = 0;
        forever #20 ddr_emif_clk = ~ddr_emif_clk;
    end

    // emif model, random ready and delayed read data
    always @(negedge ddr_emif_clk) begin
        logic [255:0] l;
        if (ddr_emif_write && ddr_emif_ready) begin
            l = model_line(ddr_emif_addr);
            for (int b = 0; b < 32; b++)
                if (ddr_emif_byte_enable[b])
                    l[b*8 +: 8] = ddr_emif_write_data[b*8 +: 8];
            line_mem[int'(ddr_emif_addr)] = l;
        end
        if (ddr_emif_read && ddr_emif_ready) begin
            rd_addr  = ddr_emif_addr;
            rd_delay = 2 + (xorshift() & 3);
        end
    end

    always @(posedge ddr_emif_clk) begin
        ddr_emif_ready        <= ddr_emif_rst_n && ((xorshift() & 3) != 0);
        ddr_emif_rddata_valid <= 1'b0;
        if (rd_delay == 1) begin
            ddr_emif_rddata_valid <= 1'b1;
            ddr_emif_read_data    <= model_line(rd_addr);
        end
        if (rd_delay > 0)
            rd_delay = rd_delay - 1;
    end

    task automatic abort_run(input string why);
        $display("%s at %0t", why, $time);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic check_idle();
        @(negedge ddr_emif_clk);
        if (ddr_emif_write || ddr_emif_read || wr_ack || rd_ack || rd_valid || wr_word_ready) begin
            $display("handshake or emif command still high while idle at %0t", $time);
            bench_errors++;
        end
    endtask

    task automatic do_write(input logic [24:0] addr, input int len);
        int  t;
        int  sent;
        bit  fire;
        @(posedge ddr_emif_clk);
        wr_cmd <= '{addr: addr, len: 8'(len)};
        wr_req <= 1'b1;
        t = 0;
        @(negedge ddr_emif_clk);
        while (!wr_ack) begin
            t++;
            if (t > TIMEOUT) abort_run("wr_ack never rose");
            @(negedge ddr_emif_clk);
        end
        @(posedge ddr_emif_clk);
        wr_req <= 1'b0;
        t = 0;
        @(negedge ddr_emif_clk);
        while (wr_ack) begin
            t++;
            if (t > TIMEOUT) abort_run("wr_ack never fell");
            @(negedge ddr_emif_clk);
        end
        sent = 0;
        t = 0;
        while (sent < len) begin
            @(negedge ddr_emif_clk);
            fire = wr_word_valid && wr_word_ready;
            @(posedge ddr_emif_clk);
            if (fire) begin
                sent++;
                t = 0;
            end else begin
                t++;
                if (t > TIMEOUT) abort_run("write words stalled");
            end
            if (sent == len) begin
                wr_word_valid <= 1'b0;
            end else if (fire || !wr_word_valid) begin
                wr_word       <= xorshift();
                wr_word_valid <= (xorshift() & 7) != 0;  // random gaps
            end
        end
        t = 0;
        @(negedge ddr_emif_clk);
        while (u_checker.pending_lines != 0 || ddr_emif_write) begin
            t++;
            if (t > TIMEOUT) abort_run("line writes never reached the emif port");
            @(negedge ddr_emif_clk);
        end
    endtask

    task automatic do_read(input logic [24:0] addr, input int len);
        int t;
        @(posedge ddr_emif_clk);
        rd_cmd <= '{addr: addr, len: 4'(len)};
        rd_req <= 1'b1;
        t = 0;
        @(negedge ddr_emif_clk);
        while (!rd_ack) begin
            t++;
            if (t > TIMEOUT) abort_run("rd_ack never rose");
            @(negedge ddr_emif_clk);
        end
        @(posedge ddr_emif_clk);
        rd_req <= 1'b0;
        t = 0;
        @(negedge ddr_emif_clk);
        while (rd_ack) begin
            t++;
            if (t > TIMEOUT) abort_run("rd_ack never fell");
            @(negedge ddr_emif_clk);
        end
    endtask

    initial begin
        int          kind;
        logic [2:0]  lane;
        logic [5:0]  line;
        ddr_emif_rst_n        = 0;
        wr_req                = 0;
        wr_cmd                = '0;
        wr_word               = '0;
        wr_word_valid         = 0;
        rd_req                = 0;
        rd_cmd                = '0;
        ddr_emif_ready        = 0;
        ddr_emif_read_data    = '0;
        ddr_emif_rddata_valid = 0;
        repeat (10) @(posedge ddr_emif_clk);
        ddr_emif_rst_n <= 1'b1;
        check_idle();
        for (int n = 0; n < 60; n++) begin
            kind = xorshift() % 3;
            lane = xorshift() % 8;
            line = xorshift() % 64;
            case (kind)
                0: do_write({16'd0, line, lane}, 1 + xorshift() % (8 - lane));  // one line
                1: do_write(xorshift() % 512, 1 + xorshift() % 40);
                default: do_read({16'd0, line, lane}, 1 + xorshift() % (8 - lane));
            endcase
            check_idle();
        end
        repeat (5) @(posedge ddr_emif_clk);
        $display("errors: checker %0d, bench %0d", u_checker.errors, bench_errors);
        if (u_checker.errors == 0 && bench_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+common
common/emif_pkg.sv
write_path/word_distributor.sv
write_path/word_lane.sv
write_path/line_writer.sv
source/read_unpacker.sv
source/emif_port_mux.sv
source/ddr3_emif_buffer.sv
bench/emif_checker.sv
bench/tb_ddr3_emif_buffer.sv
